/* hw/mouse_pkg.sv */
// shared types, register map and PS/2 frame constants; compile first, imported by all mouse RTL
`default_nettype none

package mouse_pkg;

    // PS/2 frame timing
    localparam int FRAME_BITS  = 11;    // start, 8 data, parity, stop
    localparam int IDLE_CYCLES = 2048;  // mid-frame idle limit in clk cycles

    // flags byte of the movement packet
    localparam int SYNC_BIT = 3;        // always 1 in a valid flags byte

    // Wishbone word addresses
    localparam logic [1:0] REG_P1   = 2'd0;  // player 1 {dy, dx}
    localparam logic [1:0] REG_P2   = 2'd1;  // player 2 {dy, dx}
    localparam logic [1:0] REG_BUT  = 2'd2;  // buttons of both players
    localparam logic [1:0] REG_CTRL = 2'd3;  // lock and sticky error flags

    // REG_CTRL bit positions
    localparam int CTRL_LOCK = 0;
    localparam int CTRL_ERR0 = 8;       // port 0 frame error
    localparam int CTRL_ERR1 = 9;       // port 1 frame error

    // one received byte with its frame status
    typedef struct packed {
        logic       err;                // parity or stop bit bad
        logic [7:0] data;
    } ps2_byte_t;

    // decoded three-byte movement packet
    typedef struct packed {
        logic [2:0]        buttons;     // left, right, middle
        logic signed [8:0] dx;          // sign from flags bit 4
        logic signed [8:0] dy;          // sign from flags bit 5
        logic [1:0]        overflow;    // flags bits 7:6
        logic [2:0]        pad;
    } mouse_pkt_t;

    // halved deltas as seen by the game CPU
    typedef struct packed {
        logic [7:0] dy;
        logic [7:0] dx;
    } player_word_t;

endpackage

`default_nettype wire

/* hw/ps2_rx.sv */
// PS/2 device-to-host receiver, one per mouse port; outputs checked bytes or error pulses
`default_nettype none
`timescale 1ns/1ns

module ps2_rx (
    input  logic                 rst,
    input  logic                 clk,
    input  logic                 ps2_clk,     // open collector, from mouse
    input  logic                 ps2_dat,
    output logic                 byte_valid,  // good frame, one cycle
    output mouse_pkg::ps2_byte_t rx_byte,
    output logic                 error        // bad parity or stop, one cycle
);
    import mouse_pkg::*;

    logic [1:0]                     clk_sync;  // two-flop synchronizer
    logic [1:0]                     dat_sync;  // same depth keeps data aligned to clock
    logic                           clk_prev;  // delayed clock for edge detect
    logic                           fall;
    logic [3:0]                     bit_cnt;   // 0 = waiting for start bit
    logic [8:0]                     shift;     // {parity, d7..d0} once full
    logic [$clog2(IDLE_CYCLES)-1:0] idle_cnt;
    logic                           stop_bit;
    logic                           frame_ok;

    assign fall     = clk_prev & ~clk_sync[1];
    assign stop_bit = (bit_cnt == 4'(FRAME_BITS - 1));
    assign frame_ok = (^shift) & dat_sync[1];  // odd parity and stop bit high

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clk_sync   <= 2'b11;  // bus idles high
            dat_sync   <= 2'b11;
            clk_prev   <= 1'b1;
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            byte_valid <= 1'b0;
            error      <= 1'b0;
        end else begin
            clk_sync   <= {clk_sync[0], ps2_clk};
            dat_sync   <= {dat_sync[0], ps2_dat};
            clk_prev   <= clk_sync[1];
            byte_valid <= 1'b0;
            error      <= 1'b0;
            if (fall || bit_cnt == '0) begin
                idle_cnt <= '0;  // only count while inside a frame
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
            if (fall) begin
                if (bit_cnt == '0) begin
                    if (!dat_sync[1]) begin
                        bit_cnt <= 4'd1;  // start bit seen
                    end
                end else if (stop_bit) begin
                    bit_cnt    <= '0;
                    byte_valid <= frame_ok;
                    error      <= ~frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != '0 && idle_cnt == '1) begin
                bit_cnt <= '0;  // mouse stopped clocking, drop partial frame
            end
        end
    end

    // data path, shifts LSB first
    always_ff @(posedge clk) begin
        if (fall && bit_cnt != '0 && !stop_bit) begin
            shift <= {dat_sync[1], shift[8:1]};
        end
        if (fall && stop_bit) begin
            rx_byte.data <= shift[7:0];
            rx_byte.err  <= ~frame_ok;
        end
    end

endmodule

`default_nettype wire

/* hw/mouse_packet.sv */
// collects flags, dx and dy bytes into one movement packet; resyncs on the flags sync bit
`default_nettype none
`timescale 1ns/1ns

module mouse_packet (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  byte_valid,  // good or error byte
    input  mouse_pkg::ps2_byte_t  rx_byte,
    output logic                  pkt_valid,   // one cycle per packet
    output mouse_pkg::mouse_pkt_t pkt
);
    import mouse_pkg::*;

    typedef enum logic [1:0] {
        ST_FLAGS,
        ST_DX,
        ST_DY
    } pkt_state_t;

    pkt_state_t state;
    logic [7:0] flags_q;  // first byte
    logic [7:0] dx_q;     // second byte

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_FLAGS;
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= 1'b0;
            if (byte_valid) begin
                if (rx_byte.err) begin
                    state <= ST_FLAGS;  // corrupt byte restarts the packet
                end else begin
                    case (state)
                        ST_FLAGS: if (rx_byte.data[SYNC_BIT]) state <= ST_DX;  // else drop
                        ST_DX:    state <= ST_DY;
                        ST_DY: begin
                            state     <= ST_FLAGS;
                            pkt_valid <= 1'b1;
                        end
                        default:  state <= ST_FLAGS;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && !rx_byte.err) begin
            case (state)
                ST_FLAGS: flags_q <= rx_byte.data;
                ST_DX:    dx_q    <= rx_byte.data;
                ST_DY: begin
                    pkt.buttons  <= flags_q[2:0];
                    pkt.dx       <= {flags_q[4], dx_q};          // 9-bit signed
                    pkt.dy       <= {flags_q[5], rx_byte.data};
                    pkt.overflow <= flags_q[7:6];
                    pkt.pad      <= '0;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/mouse_arbiter.sv */
// merges the two packet streams into one strobe plus player index, port 0 wins collisions
`default_nettype none
`timescale 1ns/1ns

module mouse_arbiter (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  pkt_valid0,
    input  mouse_pkg::mouse_pkt_t pkt0,
    input  logic                  pkt_valid1,
    input  mouse_pkg::mouse_pkt_t pkt1,
    output logic                  mouse_st,   // one cycle
    output logic                  mouse_idx,  // 0 = player 1
    output mouse_pkg::mouse_pkt_t pkt
);
    import mouse_pkg::*;

    logic       pend_valid;  // port 1 packet waiting
    mouse_pkt_t pend_pkt;
    logic       take_pend;   // pending entry goes out this cycle

    assign take_pend = !pkt_valid0 && pend_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mouse_st   <= 1'b0;
            mouse_idx  <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            mouse_st <= pkt_valid0 | pend_valid | pkt_valid1;
            if (pkt_valid0) begin
                mouse_idx <= 1'b0;
                if (pkt_valid1) pend_valid <= 1'b1;  // collision, park port 1
            end else if (pend_valid) begin
                mouse_idx  <= 1'b1;
                pend_valid <= pkt_valid1;            // refill if another arrives
            end else if (pkt_valid1) begin
                mouse_idx <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_valid0) begin
            pkt <= pkt0;
        end else if (take_pend) begin
            pkt <= pend_pkt;
        end else if (pkt_valid1) begin
            pkt <= pkt1;
        end
        if (pkt_valid1 && (pkt_valid0 || take_pend)) pend_pkt <= pkt1;
    end

endmodule

`default_nettype wire

/* hw/mouse_router.sv */
// halves the deltas and latches them into the selected player's word unless locked
`default_nettype none
`timescale 1ns/1ns

module mouse_router #(
    parameter bit SIGN_MAG = 1'b0  // 1 = sign plus magnitude output
) (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    lock,       // from CTRL register
    input  logic                    mouse_st,
    input  logic                    mouse_idx,
    input  mouse_pkg::mouse_pkt_t   pkt,
    output mouse_pkg::player_word_t mouse_1p,
    output mouse_pkg::player_word_t mouse_2p,
    output logic [2:0]              but_1p,
    output logic [2:0]              but_2p
);
    import mouse_pkg::*;

    player_word_t word;  // converted packet

    // drop the LSB of a 9-bit delta
    function automatic logic [7:0] cv(input logic signed [8:0] d);
        logic [6:0] mag;
        mag = d[8] ? 7'(-d[7:1]) : d[7:1];  // magnitude of the halved value
        if (SIGN_MAG) begin
            cv = {d[8], mag};
        end else begin
            cv = d[8:1];                    // plain arithmetic shift
        end
    endfunction

    assign word.dx = cv(pkt.dx);
    assign word.dy = cv(pkt.dy);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mouse_1p <= '0;
            mouse_2p <= '0;
            but_1p   <= '0;
            but_2p   <= '0;
        end else if (mouse_st && !lock) begin
            if (!mouse_idx) begin
                mouse_1p <= word;
                but_1p   <= pkt.buttons;
            end else begin
                mouse_2p <= word;
                but_2p   <= pkt.buttons;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mouse_wb_regs.sv */
// Wishbone classic slave for the CPU: player words, buttons, lock and sticky frame errors
`default_nettype none
`timescale 1ns/1ns

module mouse_wb_regs (
    input  logic                    rst,
    input  logic                    clk,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [1:0]              adr,     // word address
    input  logic [15:0]             dat_w,
    output logic [15:0]             dat_r,
    output logic                    ack,
    input  mouse_pkg::player_word_t mouse_1p,
    input  mouse_pkg::player_word_t mouse_2p,
    input  logic [2:0]              but_1p,
    input  logic [2:0]              but_2p,
    input  logic                    err0,    // pulse from port 0 receiver
    input  logic                    err1,
    output logic                    lock
);
    import mouse_pkg::*;

    logic        req;
    logic        done;     // acked, waiting for stb to drop
    logic        access;   // first cycle of a new transfer
    logic        wr_ctrl;
    logic [1:0]  err_q;    // sticky flags, bit 0 = port 0
    logic [15:0] rd_data;

    assign req     = cyc & stb;
    assign access  = req & ~ack & ~done;
    assign wr_ctrl = access & we & (adr == REG_CTRL);

    always_comb begin
        rd_data = '0;
        case (adr)
            REG_P1:  rd_data = mouse_1p;
            REG_P2:  rd_data = mouse_2p;
            REG_BUT: rd_data = {9'd0, but_2p, 1'b0, but_1p};
            default: begin
                rd_data[CTRL_LOCK] = lock;
                rd_data[CTRL_ERR0] = err_q[0];
                rd_data[CTRL_ERR1] = err_q[1];
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack   <= 1'b0;
            done  <= 1'b0;
            lock  <= 1'b0;
            err_q <= '0;
        end else begin
            ack  <= access;                // exactly one cycle after request
            done <= req & (done | ack);    // cleared once the master lets go
            if (wr_ctrl) lock <= dat_w[CTRL_LOCK];
            // write-one-to-clear, a new pulse wins over the clear
            err_q[0] <= (err_q[0] & ~(wr_ctrl & dat_w[CTRL_ERR0])) | err0;
            err_q[1] <= (err_q[1] & ~(wr_ctrl & dat_w[CTRL_ERR1])) | err1;
        end
    end

    always_ff @(posedge clk) begin
        if (access) dat_r <= rd_data;  // held until the next transfer
    end

endmodule

`default_nettype wire

/* hw/mouse_top.sv */
// dual PS/2 mouse subsystem top, connects to two mouse ports and a Wishbone CPU bus
`default_nettype none
`timescale 1ns/1ns

module mouse_top #(
    parameter bit SIGN_MAG = 1'b0  // output format of the router
) (
    input  logic        rst,
    input  logic        clk,
    input  logic        ps2_clk0,
    input  logic        ps2_dat0,
    input  logic        ps2_clk1,
    input  logic        ps2_dat1,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [1:0]  adr,
    input  logic [15:0] dat_w,
    output logic [15:0] dat_r,
    output logic        ack
);
    import mouse_pkg::*;

    logic         byte_valid0, byte_valid1;
    ps2_byte_t    rx_byte0, rx_byte1;
    logic         err0, err1;
    logic         pkt_valid0, pkt_valid1;
    mouse_pkt_t   pkt0, pkt1;
    logic         mouse_st;
    logic         mouse_idx;
    mouse_pkt_t   pkt;            // arbiter output
    player_word_t mouse_1p, mouse_2p;
    logic [2:0]   but_1p, but_2p;
    logic         lock;

    // port 0 chain, error bytes also reach the assembler to restart it
    ps2_rx u_rx0 (
        .rst(rst), .clk(clk), .ps2_clk(ps2_clk0), .ps2_dat(ps2_dat0),
        .byte_valid(byte_valid0), .rx_byte(rx_byte0), .error(err0)
    );
    mouse_packet u_pkt0 (
        .rst(rst), .clk(clk), .byte_valid(byte_valid0 | err0), .rx_byte(rx_byte0),
        .pkt_valid(pkt_valid0), .pkt(pkt0)
    );

    // port 1 chain
    ps2_rx u_rx1 (
        .rst(rst), .clk(clk), .ps2_clk(ps2_clk1), .ps2_dat(ps2_dat1),
        .byte_valid(byte_valid1), .rx_byte(rx_byte1), .error(err1)
    );
    mouse_packet u_pkt1 (
        .rst(rst), .clk(clk), .byte_valid(byte_valid1 | err1), .rx_byte(rx_byte1),
        .pkt_valid(pkt_valid1), .pkt(pkt1)
    );

    mouse_arbiter u_arb (
        .rst(rst), .clk(clk),
        .pkt_valid0(pkt_valid0), .pkt0(pkt0), .pkt_valid1(pkt_valid1), .pkt1(pkt1),
        .mouse_st(mouse_st), .mouse_idx(mouse_idx), .pkt(pkt)
    );

    mouse_router #(.SIGN_MAG(SIGN_MAG)) u_router (
        .rst(rst), .clk(clk), .lock(lock), .mouse_st(mouse_st), .mouse_idx(mouse_idx),
        .pkt(pkt), .mouse_1p(mouse_1p), .mouse_2p(mouse_2p), .but_1p(but_1p), .but_2p(but_2p)
    );

    mouse_wb_regs u_regs (
        .rst(rst), .clk(clk), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_w(dat_w), .dat_r(dat_r), .ack(ack),
        .mouse_1p(mouse_1p), .mouse_2p(mouse_2p), .but_1p(but_1p), .but_2p(but_2p),
        .err0(err0), .err1(err1), .lock(lock)
    );

endmodule

`default_nettype wire

/* dv/mouse_checker.sv */
// protocol assertions for the mouse subsystem, bound into mouse_top by the bind at the bottom
`default_nettype none
`timescale 1ns/1ns

module mouse_checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    cyc,
    input logic                    stb,
    input logic                    ack,
    input logic                    lock,
    input logic                    mouse_st,
    input mouse_pkg::player_word_t mouse_1p,
    input mouse_pkg::player_word_t mouse_2p,
    input logic [2:0]              but_1p,
    input logic [2:0]              but_2p
);
    import mouse_pkg::*;

    // one ack per transfer, none again while the master still holds the strobe
    ack_single: assert property (@(posedge clk) disable iff (rst)
        ack |-> (!$past(ack) && !($past(ack, 2) && $past(cyc && stb))))
        else $error("ack repeated within one transfer");

    ack_after_req: assert property (@(posedge clk) disable iff (rst) ack |-> $past(cyc && stb))
        else $error("ack without a preceding cyc and stb");

    // a strobe under lock leaves both players untouched
    locked_hold: assert property (@(posedge clk) disable iff (rst)
        (lock && mouse_st) |=> ($stable(mouse_1p) && $stable(mouse_2p) &&
                                $stable(but_1p) && $stable(but_2p)))
        else $error("player state changed while locked");

endmodule

bind mouse_top mouse_checker u_checker (
    .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .ack(ack), .lock(lock),
    .mouse_st(mouse_st), .mouse_1p(mouse_1p), .mouse_2p(mouse_2p),
    .but_1p(but_1p), .but_2p(but_2p)
);

`default_nettype wire

/* dv/mouse_tb.sv */
// testbench for the dual PS/2 mouse subsystem, sends mouse frames and checks registers over Wishbone
`default_nettype none
`timescale 1ns/1ns

module mouse_tb;
    import mouse_pkg::*;

    localparam int NROWS      = 11;
    localparam int PS2_HALF   = 10;  // system cycles per PS/2 clock phase
    localparam int ACK_LIMIT  = 20;
    localparam int POLL_LIMIT = 40;

    typedef struct packed {
        logic [1:0]  port;           // 2 = both ports at once
        logic [7:0]  flags;
        logic [7:0]  dx;
        logic [7:0]  dy;
        logic        lock;
        logic        bad_par;        // corrupts the dy frame
        logic        junk;           // leading flags byte with sync bit clear
        logic [15:0] exp_p1;
        logic [15:0] exp_p2;
        logic [15:0] exp_but;
        logic [15:0] exp_ctrl;
    } row_t;

    logic        clk;
    logic        rst;
    logic        ps2_clk0, ps2_dat0, ps2_clk1, ps2_dat1;
    logic        cyc, stb, we;
    logic [1:0]  adr;
    logic [15:0] dat_w, dat_r;
    logic        ack;
    row_t        rows [NROWS];
    string       names [NROWS];
    integer      seed;
    int          nrow;
    logic [15:0] m_p1, m_p2;        // register model
    logic [2:0]  m_b1, m_b2;

    mouse_top #(.SIGN_MAG(1'b0)) DUT (
        .rst(rst), .clk(clk), .ps2_clk0(ps2_clk0), .ps2_dat0(ps2_dat0),
        .ps2_clk1(ps2_clk1), .ps2_dat1(ps2_dat1), .cyc(cyc), .stb(stb), .we(we),
        .adr(adr), .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) stop_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;  // inputs move just after the edge
    endtask

    task automatic drive_line(input int port, input logic c, input logic d);
        if (port == 1) begin
            ps2_clk1 = c;
            ps2_dat1 = d;
        end else begin
            ps2_clk0 = c;
            ps2_dat0 = d;
        end
    endtask

    task automatic send_frame(input int port, input logic [7:0] data, input logic bad_par);
        logic [10:0] bits;
        bits = {1'b1, ~(^data) ^ bad_par, data, 1'b0};  // stop, odd parity, data, start
        for (int i = 0; i < 11; i++) begin
            drive_line(port, 1'b1, bits[i]);  // mouse changes data while clock high
            step(PS2_HALF);
            drive_line(port, 1'b0, bits[i]);  // receiver samples on this fall
            step(PS2_HALF);
        end
        drive_line(port, 1'b1, 1'b1);
        step(2 * PS2_HALF);  // gap between frames
    endtask

    task automatic send_packet(input int port, input logic [7:0] f, input logic [7:0] dx,
                               input logic [7:0] dy, input logic junk, input logic bad_par);
        if (junk) send_frame(port, f & ~(8'd1 << SYNC_BIT), 1'b0);  // out of sync byte
        send_frame(port, f, 1'b0);
        send_frame(port, dx, 1'b0);
        send_frame(port, dy, bad_par);
    endtask

    task automatic wb_transfer(input logic wr, input logic [1:0] a, input logic [15:0] wdata,
                               output logic [15:0] rdata);
        int n;
        n = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = a;
        dat_w = wdata;
        step(1);
        while (!ack) begin
            if (n == ACK_LIMIT) stop_run("Wishbone transfer got no ack before the timeout");
            n++;
            step(1);
        end
        rdata = dat_r;
        step(2);  // master keeps the strobe up past the ack
        if (ack) stop_run("Wishbone ack repeated while the strobe was still held");
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        step(1);  // ack drops before the next request
    endtask

    // keep the player word once the packet has had time to land
    task automatic wait_word(input logic [1:0] a, input logic [15:0] exp);
        logic [15:0] v;
        int n;
        n = 0;
        wb_transfer(1'b0, a, 16'h0, v);
        while (v !== exp) begin
            if (n == POLL_LIMIT) stop_run("player word never reached the expected value");
            n++;
            wb_transfer(1'b0, a, 16'h0, v);
        end
    endtask

    // a 9-bit signed delta keeps its upper 8 bits
    function automatic logic [7:0] halve_delta(input logic sign, input logic [7:0] b);
        logic signed [8:0] v;
        v = {sign, b};
        halve_delta = 8'(v >>> 1);
    endfunction

    task automatic add_row(input string name, input int port, input logic [7:0] f,
                           input logic [7:0] dx, input logic [7:0] dy,
                           input logic lock, input logic bad_par, input logic junk);
        row_t r;
        logic [7:0] f1;
        f1 = f ^ 8'h07;  // port 1 partner packet in the collision row
        if (!lock && !bad_par) begin
            if (port != 1) begin
                m_p1 = {halve_delta(f[5], dy), halve_delta(f[4], dx)};
                m_b1 = f[2:0];
            end
            if (port == 1) begin
                m_p2 = {halve_delta(f[5], dy), halve_delta(f[4], dx)};
                m_b2 = f[2:0];
            end else if (port == 2) begin
                m_p2 = {halve_delta(f1[5], ~dy), halve_delta(f1[4], ~dx)};
                m_b2 = f1[2:0];
            end
        end
        r          = '0;
        r.port     = 2'(port);
        r.flags    = f;
        r.dx       = dx;
        r.dy       = dy;
        r.lock     = lock;
        r.bad_par  = bad_par;
        r.junk     = junk;
        r.exp_p1   = m_p1;
        r.exp_p2   = m_p2;
        r.exp_but  = {9'd0, m_b2, 1'b0, m_b1};
        r.exp_ctrl[CTRL_LOCK] = lock;
        if (bad_par) r.exp_ctrl[port == 1 ? CTRL_ERR1 : CTRL_ERR0] = 1'b1;
        rows[nrow]  = r;
        names[nrow] = name;
        nrow++;
    endtask

    initial begin
        row_t        r;
        logic [15:0] v;
        logic [15:0] ctrl_w;
        seed = 99205;
        rst  = 1'b1;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
        adr  = 2'd0;
        dat_w = 16'h0;
        drive_line(0, 1'b1, 1'b1);  // PS/2 lines idle high
        drive_line(1, 1'b1, 1'b1);
        nrow = 0;
        m_p1 = '0;
        m_p2 = '0;
        m_b1 = '0;
        m_b2 = '0;
        add_row("p0_positive", 0, 8'h09, 8'h20, 8'h10, 1'b0, 1'b0, 1'b0);
        add_row("p0_negative", 0, 8'h3A, 8'hF0, 8'h81, 1'b0, 1'b0, 1'b0);
        add_row("p1_random", 1, 8'h0C, 8'($random(seed)), 8'($random(seed)), 1'b0, 1'b0, 1'b0);
        add_row("p0_random", 0, 8'h19, 8'($random(seed)), 8'($random(seed)), 1'b0, 1'b0, 1'b0);
        add_row("p0_locked", 0, 8'h0B, 8'($random(seed)), 8'($random(seed)), 1'b1, 1'b0, 1'b0);
        add_row("p1_unlocked", 1, 8'h2D, 8'($random(seed)), 8'($random(seed)), 1'b0, 1'b0, 1'b0);
        add_row("p0_bad_parity", 0, 8'h0F, 8'h44, 8'h22, 1'b0, 1'b1, 1'b0);
        add_row("p0_after_clear", 0, 8'h18, 8'($random(seed)), 8'h66, 1'b0, 1'b0, 1'b0);
        add_row("p1_bad_parity", 1, 8'h0A, 8'h12, 8'h34, 1'b0, 1'b1, 1'b0);
        add_row("p1_resync", 1, 8'h1E, 8'($random(seed)), 8'($random(seed)), 1'b0, 1'b0, 1'b1);
        add_row("both_ports", 2, 8'h29, 8'($random(seed)), 8'($random(seed)), 1'b0, 1'b0, 1'b0);
        step(10);
        rst = 1'b0;
        step(2);
        for (int i = 0; i < nrow; i++) begin
            r      = rows[i];
            ctrl_w = '0;
            ctrl_w[CTRL_LOCK] = r.lock;
            ctrl_w[CTRL_ERR0] = 1'b1;  // clear both sticky flags
            ctrl_w[CTRL_ERR1] = 1'b1;
            wb_transfer(1'b1, REG_CTRL, ctrl_w, v);
            if (r.port == 2'd2) begin
                fork
                    send_packet(0, r.flags, r.dx, r.dy, r.junk, r.bad_par);
                    send_packet(1, r.flags ^ 8'h07, ~r.dx, ~r.dy, r.junk, r.bad_par);
                join
            end else begin
                send_packet(int'(r.port), r.flags, r.dx, r.dy, r.junk, r.bad_par);
            end
            wait_word(r.port == 2'd0 ? REG_P1 : REG_P2, r.port == 2'd0 ? r.exp_p1 : r.exp_p2);
            wb_transfer(1'b0, REG_P1, 16'h0, v);
            check({names[i], " REG_P1"}, r.exp_p1, v);
            wb_transfer(1'b0, REG_P2, 16'h0, v);
            check({names[i], " REG_P2"}, r.exp_p2, v);
            wb_transfer(1'b0, REG_BUT, 16'h0, v);
            check({names[i], " REG_BUT"}, r.exp_but, v);
            wb_transfer(1'b0, REG_CTRL, 16'h0, v);
            check({names[i], " REG_CTRL"}, r.exp_ctrl, v);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hw/mouse_pkg.sv
hw/ps2_rx.sv
hw/mouse_packet.sv
hw/mouse_arbiter.sv
hw/mouse_router.sv
hw/mouse_wb_regs.sv
hw/mouse_top.sv
dv/mouse_checker.sv
dv/mouse_tb.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module mouse_tb

sim:
	verilator --binary --timing --assert -f vlog.f --top-module mouse_tb -Mdir obj_dir
	out=$$(./obj_dir/Vmouse_tb); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
